// ==== rtl/rsa_pkg.sv ====
`default_nettype none

package rsa_pkg;

  // Operand width for every big-number value
  localparam int op_width = 128;

  typedef logic [op_width-1:0] operand_t;
  typedef logic [31:0]         word_t;
  typedef logic [31:0]         addr_t;
  typedef logic [31:0]         exp_len_t;

  // Host parameter block, command word first
  typedef struct packed {
    word_t    command;
    addr_t    addr_m;
    addr_t    addr_e;
    addr_t    addr_x;
    addr_t    addr_r;
    addr_t    addr_r2;
    exp_len_t exp_len;
    addr_t    addr_result;
  } host_regs_t;

  typedef struct packed {
    logic [28:0] reserved;
    logic        dma_error;
    logic        is_idle;
    logic        is_done;
  } status_t;

  typedef struct packed {
    logic  rx_start;
    addr_t rx_addr;
    logic  tx_start;
    addr_t tx_addr;
  } dma_req_t;

  typedef struct packed {
    logic done;
    logic idle;
    logic error;
  } dma_rsp_t;

  typedef struct packed {
    operand_t m;
    operand_t e;
    operand_t x;
    operand_t r;
    operand_t r2;
    exp_len_t exp_len;
  } ladder_ops_t;

  localparam word_t cmd_idle    = 32'd0;
  localparam word_t cmd_compute = 32'd1;

endpackage

`default_nettype wire

// ==== rtl/mont_mult.sv ====
`default_nettype none

module mont_mult (
  input  wire                    clk,
  input  wire                    resetn,
  input  wire                    mult_start,
  input  wire rsa_pkg::operand_t a_op,
  input  wire rsa_pkg::operand_t b_op,
  input  wire rsa_pkg::operand_t mod_op,
  output rsa_pkg::operand_t      product,
  output logic                   mult_done
);

  localparam int cnt_width = $clog2(rsa_pkg::op_width + 1);
  localparam logic [cnt_width-1:0] last_iter = cnt_width'(rsa_pkg::op_width - 1);

  typedef enum logic [1:0] {idle, run, reduce} state_t;

  state_t                        state;
  logic [cnt_width-1:0]          count;
  rsa_pkg::operand_t             a_q;
  rsa_pkg::operand_t             b_q;
  rsa_pkg::operand_t             m_q;
  // One bit of headroom, the running value stays below 2m
  logic [rsa_pkg::op_width:0]    acc;
  logic [rsa_pkg::op_width+1:0]  sum_ab;
  logic [rsa_pkg::op_width+1:0]  sum_abm;
  logic [rsa_pkg::op_width:0]    diff;
  logic                          q_bit;

  // One radix-2 step: add a_i*b, make it even with q*m, halve
  always_comb begin
    sum_ab  = {1'b0, acc} + (a_q[0] ? {2'b00, b_q} : '0);
    q_bit   = sum_ab[0];
    sum_abm = sum_ab + (q_bit ? {2'b00, m_q} : '0);
    diff    = acc - {1'b0, m_q};
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= idle;
      count     <= '0;
      mult_done <= 1'b0;
    end else begin
      mult_done <= 1'b0;
      case (state)
        idle: begin
          if (mult_start) begin
            state <= run;
            count <= '0;
          end
        end
        run: begin
          count <= count + 1'b1;
          if (count == last_iter) begin
            state <= reduce;
          end
        end
        reduce: begin
          state     <= idle;
          mult_done <= 1'b1;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (mult_start) begin
          a_q <= a_op;
          b_q <= b_op;
          m_q <= mod_op;
          acc <= '0;
        end
      end
      run: begin
        acc <= sum_abm[rsa_pkg::op_width+1:1];
        a_q <= a_q >> 1;
      end
      reduce: begin
        // Final conditional subtraction
        product <= (acc >= {1'b0, m_q}) ? diff[rsa_pkg::op_width-1:0]
                                        : acc[rsa_pkg::op_width-1:0];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mont_ladder.sv ====
`default_nettype none

module mont_ladder (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire                       start,
  input  wire rsa_pkg::ladder_ops_t ops,
  output rsa_pkg::operand_t         result,
  output logic                      done,
  output rsa_pkg::operand_t         a_op,
  output rsa_pkg::operand_t         b_op,
  output rsa_pkg::operand_t         mod_op,
  output logic                      mult_start,
  input  wire rsa_pkg::operand_t    product,
  input  wire                       mult_done
);

  typedef enum logic [3:0] {
    idle,
    xx_issue,
    xx_wait,
    step1_issue,
    step1_wait,
    step2_issue,
    step2_wait,
    fin_issue,
    fin_wait
  } state_t;

  state_t              state;
  rsa_pkg::operand_t   a_q;
  rsa_pkg::operand_t   xx_q;
  // Exponent aligned so the current bit sits at the top
  rsa_pkg::operand_t   e_q;
  rsa_pkg::exp_len_t   bits_left;
  rsa_pkg::operand_t   sq_op;
  logic                e_bit;

  assign e_bit  = e_q[rsa_pkg::op_width-1];
  assign sq_op  = e_bit ? xx_q : a_q;
  assign mod_op = ops.m;
  assign result = a_q;

  // Multiplier operand select
  always_comb begin
    a_op       = a_q;
    b_op       = xx_q;
    mult_start = 1'b0;
    case (state)
      xx_issue: begin
        a_op       = ops.x;
        b_op       = ops.r2;
        mult_start = 1'b1;
      end
      step1_issue: begin
        mult_start = 1'b1;
      end
      step2_issue: begin
        a_op       = sq_op;
        b_op       = sq_op;
        mult_start = 1'b1;
      end
      fin_issue: begin
        // Multiply by one to leave the Montgomery domain
        b_op       = rsa_pkg::operand_t'(1);
        mult_start = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= idle;
      done      <= 1'b0;
      bits_left <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state     <= xx_issue;
            bits_left <= ops.exp_len;
          end
        end
        xx_issue: state <= xx_wait;
        xx_wait: begin
          if (mult_done) begin
            state <= (bits_left == '0) ? fin_issue : step1_issue;
          end
        end
        step1_issue: state <= step1_wait;
        step1_wait: begin
          if (mult_done) begin
            state <= step2_issue;
          end
        end
        step2_issue: state <= step2_wait;
        step2_wait: begin
          if (mult_done) begin
            bits_left <= bits_left - 1'b1;
            state     <= (bits_left == 32'd1) ? fin_issue : step1_issue;
          end
        end
        fin_issue: state <= fin_wait;
        fin_wait: begin
          if (mult_done) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Ladder registers, written back from the multiplier
  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) begin
          a_q <= ops.r;
          e_q <= ops.e << (rsa_pkg::op_width - ops.exp_len);
        end
      end
      xx_wait: begin
        if (mult_done) begin
          xx_q <= product;
        end
      end
      step1_wait: begin
        if (mult_done) begin
          if (e_bit) begin
            a_q <= product;
          end else begin
            xx_q <= product;
          end
        end
      end
      step2_wait: begin
        if (mult_done) begin
          if (e_bit) begin
            xx_q <= product;
          end else begin
            a_q <= product;
          end
          e_q <= e_q << 1;
        end
      end
      fin_wait: begin
        if (mult_done) begin
          a_q <= product;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rsa_ctrl.sv ====
`default_nettype none

module rsa_ctrl (
  input  wire                      clk,
  input  wire                      resetn,
  input  wire rsa_pkg::host_regs_t host_regs,
  output rsa_pkg::status_t         status,
  output rsa_pkg::dma_req_t        dma_req,
  input  wire rsa_pkg::dma_rsp_t   dma_rsp,
  input  wire rsa_pkg::operand_t   rx_data,
  output rsa_pkg::operand_t        tx_data,
  output rsa_pkg::ladder_ops_t     ops,
  output logic                     ladder_start,
  input  wire                      ladder_done,
  input  wire rsa_pkg::operand_t   ladder_result
);

  typedef enum logic [2:0] {
    idle,
    rx_issue,
    rx_wait,
    compute,
    compute_wait,
    tx_issue,
    tx_wait,
    done
  } state_t;

  // Fetch order is M, E, X, R, R2
  localparam logic [2:0] last_fetch = 3'd4;

  state_t                state;
  logic [2:0]            fetch_idx;
  rsa_pkg::addr_t        fetch_addr;
  rsa_pkg::ladder_ops_t  ops_q;
  rsa_pkg::operand_t     result_q;
  logic                  cmd_is_compute;
  logic                  cmd_is_idle;

  assign cmd_is_compute = (host_regs.command == rsa_pkg::cmd_compute);
  assign cmd_is_idle    = (host_regs.command == rsa_pkg::cmd_idle);

  always_comb begin
    case (fetch_idx)
      3'd0:    fetch_addr = host_regs.addr_m;
      3'd1:    fetch_addr = host_regs.addr_e;
      3'd2:    fetch_addr = host_regs.addr_x;
      3'd3:    fetch_addr = host_regs.addr_r;
      default: fetch_addr = host_regs.addr_r2;
    endcase
  end

  // Start bits stay up until the engine drops idle
  always_comb begin
    dma_req          = '0;
    dma_req.rx_start = (state == rx_issue);
    dma_req.rx_addr  = fetch_addr;
    dma_req.tx_start = (state == tx_issue);
    dma_req.tx_addr  = host_regs.addr_result;
  end

  always_comb begin
    status           = '0;
    status.dma_error = dma_rsp.error;
    status.is_idle   = (state == idle);
    status.is_done   = (state == done);
  end

  assign ladder_start = (state == compute);
  assign ops          = ops_q;
  assign tx_data      = result_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= idle;
      fetch_idx <= '0;
    end else begin
      case (state)
        idle: begin
          if (cmd_is_compute) begin
            state     <= rx_issue;
            fetch_idx <= '0;
          end
        end
        rx_issue: begin
          if (!dma_rsp.idle) begin
            state <= rx_wait;
          end
        end
        rx_wait: begin
          if (dma_rsp.done) begin
            if (fetch_idx == last_fetch) begin
              state     <= compute;
              fetch_idx <= '0;
            end else begin
              state     <= rx_issue;
              fetch_idx <= fetch_idx + 1'b1;
            end
          end
        end
        compute: state <= compute_wait;
        compute_wait: begin
          if (ladder_done) begin
            state <= tx_issue;
          end
        end
        tx_issue: begin
          if (!dma_rsp.idle) begin
            state <= tx_wait;
          end
        end
        tx_wait: begin
          if (dma_rsp.done) begin
            state <= done;
          end
        end
        done: begin
          // Hold here so a lingering compute command does not restart
          if (cmd_is_idle) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge clk) begin
    if (state == idle && cmd_is_compute) begin
      ops_q.exp_len <= host_regs.exp_len;
    end
    if (state == rx_wait && dma_rsp.done) begin
      case (fetch_idx)
        3'd0:    ops_q.m  <= rx_data;
        3'd1:    ops_q.e  <= rx_data;
        3'd2:    ops_q.x  <= rx_data;
        3'd3:    ops_q.r  <= rx_data;
        default: ops_q.r2 <= rx_data;
      endcase
    end
    if (state == compute_wait && ladder_done) begin
      result_q <= ladder_result;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rsa_top.sv ====
`default_nettype none

module rsa_top (
  input  wire                      clk,
  input  wire                      resetn,
  input  wire rsa_pkg::host_regs_t host_regs,
  output rsa_pkg::status_t         status,
  output rsa_pkg::dma_req_t        dma_req,
  input  wire rsa_pkg::dma_rsp_t   dma_rsp,
  input  wire rsa_pkg::operand_t   rx_data,
  output rsa_pkg::operand_t        tx_data
);

  rsa_pkg::ladder_ops_t ops;
  logic                 ladder_start;
  logic                 ladder_done;
  rsa_pkg::operand_t    ladder_result;

  // Multiplier operands from the ladder
  rsa_pkg::operand_t    a_op;
  rsa_pkg::operand_t    b_op;
  rsa_pkg::operand_t    mod_op;
  logic                 mult_start;
  rsa_pkg::operand_t    product;
  logic                 mult_done;

  rsa_ctrl ctrl0 (
    .clk           (clk),
    .resetn        (resetn),
    .host_regs     (host_regs),
    .status        (status),
    .dma_req       (dma_req),
    .dma_rsp       (dma_rsp),
    .rx_data       (rx_data),
    .tx_data       (tx_data),
    .ops           (ops),
    .ladder_start  (ladder_start),
    .ladder_done   (ladder_done),
    .ladder_result (ladder_result)
  );

  mont_ladder ladder0 (
    .clk        (clk),
    .resetn     (resetn),
    .start      (ladder_start),
    .ops        (ops),
    .result     (ladder_result),
    .done       (ladder_done),
    .a_op       (a_op),
    .b_op       (b_op),
    .mod_op     (mod_op),
    .mult_start (mult_start),
    .product    (product),
    .mult_done  (mult_done)
  );

  mont_mult mult0 (
    .clk        (clk),
    .resetn     (resetn),
    .mult_start (mult_start),
    .a_op       (a_op),
    .b_op       (b_op),
    .mod_op     (mod_op),
    .product    (product),
    .mult_done  (mult_done)
  );

endmodule

`default_nettype wire

// ==== test/tb_rsa_chk.sv ====
`default_nettype none

module tb_rsa_chk (
  input wire                      clk,
  input wire                      resetn,
  input wire rsa_pkg::host_regs_t host_regs,
  input wire rsa_pkg::status_t    status,
  input wire rsa_pkg::dma_req_t   dma_req
);

  // High from a write request until the controller is idle again
  logic tx_seen;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_seen <= 1'b0;
    end else if (dma_req.tx_start) begin
      tx_seen <= 1'b1;
    end else if (status.is_idle) begin
      tx_seen <= 1'b0;
    end
  end

  a_one_start: assert property (@(posedge clk) disable iff (!resetn)
    !(dma_req.rx_start && dma_req.tx_start))
    else $error("rx_start and tx_start are high together");

  a_done_idle: assert property (@(posedge clk) disable iff (!resetn)
    !(status.is_done && status.is_idle))
    else $error("is_done and is_idle are high together");

  a_done_hold: assert property (@(posedge clk) disable iff (!resetn)
    (status.is_done && host_regs.command == rsa_pkg::cmd_compute) |=> status.is_done)
    else $error("is_done dropped while the command is still compute");

  a_no_refetch: assert property (@(posedge clk) disable iff (!resetn)
    tx_seen |-> !$rose(dma_req.rx_start))
    else $error("rx_start rose after the result write, before idle");

endmodule

bind rsa_top tb_rsa_chk chk0 (
  .clk       (clk),
  .resetn    (resetn),
  .host_regs (host_regs),
  .status    (status),
  .dma_req   (dma_req)
);

`default_nettype wire

// ==== test/tb_rsa.sv ====
`default_nettype none

module tb_rsa;

  localparam int num_tests = 3;
  localparam rsa_pkg::addr_t addr_base   = 32'h0000_1000;
  localparam rsa_pkg::addr_t result_base = 32'h0000_8000;

  typedef enum {w_rx_start, w_tx_start, w_is_done, w_is_idle} wait_sig_t;

  logic                  clk;
  logic                  resetn;
  rsa_pkg::host_regs_t   host_regs;
  rsa_pkg::status_t      status;
  rsa_pkg::dma_req_t     dma_req;
  rsa_pkg::dma_rsp_t     dma_rsp;
  rsa_pkg::operand_t     rx_data;
  rsa_pkg::operand_t     tx_data;

  // Seven values per test: M, E, X, R, R2, exp_len, expected result
  rsa_pkg::operand_t     vec [0:num_tests*7-1];
  logic [15:0]           lfsr_q;
  int                    checks;
  int                    errors;

  rsa_top dut0 (
    .clk       (clk),
    .resetn    (resetn),
    .host_regs (host_regs),
    .status    (status),
    .dma_req   (dma_req),
    .dma_rsp   (dma_rsp),
    .rx_data   (rx_data),
    .tx_data   (tx_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_delay(output int cycles);
    cycles = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      cycles = (cycles << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic int vec_index(input rsa_pkg::addr_t a);
    return int'((a - addr_base) >> 8) * 7 + int'(a[7:4]);
  endfunction

  function automatic rsa_pkg::status_t make_status(input logic done_bit, input logic idle_bit,
                                                   input logic err_bit);
    rsa_pkg::status_t s;
    s           = '0;
    s.is_done   = done_bit;
    s.is_idle   = idle_bit;
    s.dma_error = err_bit;
    return s;
  endfunction

  task automatic check_operand(input string name, input rsa_pkg::operand_t got,
                               input rsa_pkg::operand_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input rsa_pkg::addr_t got,
                            input rsa_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input rsa_pkg::status_t got,
                              input rsa_pkg::status_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic probe(input wait_sig_t sig);
    logic v;
    case (sig)
      w_rx_start: v = dma_req.rx_start;
      w_tx_start: v = dma_req.tx_start;
      w_is_done:  v = status.is_done;
      default:    v = status.is_idle;
    endcase
    return v;
  endfunction

  task automatic wait_for(input wait_sig_t sig, input int limit);
    int n;
    n = 0;
    while (!probe(sig) && n < limit) begin
      step();
      n++;
    end
    if (!probe(sig)) begin
      $display("Timeout after %0d cycles waiting for %s", limit, sig.name());
      $display("Finished with errors");
      $finish;
    end
  endtask

  // Read served from the requested address, with random accept and done delays
  task automatic serve_rx(input rsa_pkg::addr_t exp_addr);
    rsa_pkg::addr_t a;
    int d;
    wait_for(w_rx_start, 40);
    a = dma_req.rx_addr;
    check_addr("dma_req.rx_addr", a, exp_addr);
    rand_delay(d);
    repeat (d) step();
    dma_rsp.idle = 1'b0;
    step();
    rand_delay(d);
    repeat (d) step();
    dma_rsp.done = 1'b1;
    rx_data      = vec[vec_index(a)];
    step();
    dma_rsp.done = 1'b0;
    dma_rsp.idle = 1'b1;
  endtask

  task automatic serve_tx(input rsa_pkg::addr_t exp_addr, input rsa_pkg::operand_t exp_data);
    int d;
    wait_for(w_tx_start, 50000);
    check_addr("dma_req.tx_addr", dma_req.tx_addr, exp_addr);
    rand_delay(d);
    repeat (d) step();
    dma_rsp.idle = 1'b0;
    step();
    check_operand("tx_data", tx_data, exp_data);
    rand_delay(d);
    repeat (d) step();
    dma_rsp.done = 1'b1;
    step();
    dma_rsp.done = 1'b0;
    dma_rsp.idle = 1'b1;
  endtask

  task automatic hold_done(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      step();
      check_status("status", status, make_status(1'b1, 1'b0, 1'b0));
      checks++;
      if (dma_req.rx_start || dma_req.tx_start) begin
        $display("A DMA request started at %0t while done was held", $time);
        errors++;
      end
    end
  endtask

  // Error bit passes straight through to status
  task automatic check_error_flag();
    dma_rsp.error = 1'b1;
    step();
    check_status("status", status, make_status(1'b0, 1'b1, 1'b1));
    dma_rsp.error = 1'b0;
    step();
    check_status("status", status, make_status(1'b0, 1'b1, 1'b0));
  endtask

  task automatic run_test(input int t);
    rsa_pkg::addr_t base;
    int errors_before;
    base                  = addr_base + rsa_pkg::addr_t'(t * 256);
    errors_before         = errors;
    host_regs.addr_m      = base;
    host_regs.addr_e      = base + 32'h10;
    host_regs.addr_x      = base + 32'h20;
    host_regs.addr_r      = base + 32'h30;
    host_regs.addr_r2     = base + 32'h40;
    host_regs.exp_len     = vec[t*7+5][31:0];
    host_regs.addr_result = result_base + rsa_pkg::addr_t'(t * 256);
    host_regs.command     = rsa_pkg::cmd_compute;
    for (int k = 0; k < 5; k++) begin
      serve_rx(base + rsa_pkg::addr_t'(k * 16));
    end
    serve_tx(host_regs.addr_result, vec[t*7+6]);
    wait_for(w_is_done, 20);
    hold_done(24);
    host_regs.command = rsa_pkg::cmd_idle;
    wait_for(w_is_idle, 20);
    check_status("status", status, make_status(1'b0, 1'b1, 1'b0));
    $display("Test %0d (exp_len %0d): %0d mismatches", t, host_regs.exp_len,
             errors - errors_before);
  endtask

  initial begin
    resetn    = 1'b0;
    host_regs = '0;
    dma_rsp   = '0;
    dma_rsp.idle = 1'b1;
    rx_data   = '0;
    lfsr_q    = 16'd32728;
    checks    = 0;
    errors    = 0;
    $readmemh("test/rsa_input.hex", vec);
    repeat (4) @(posedge clk);
    #1;
    resetn = 1'b1;
    step();
    check_status("status", status, make_status(1'b0, 1'b1, 1'b0));
    checks++;
    if (dma_req.rx_start || dma_req.tx_start) begin
      $display("A DMA start bit is high after reset");
      errors++;
    end
    check_error_flag();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rsa_copro.f ====
rtl/rsa_pkg.sv
rtl/mont_mult.sv
rtl/mont_ladder.sv
rtl/rsa_ctrl.sv
rtl/rsa_top.sv
test/tb_rsa_chk.sv
test/tb_rsa.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RSA coprocessor testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rsa -f rsa_copro.f -o sim_rsa

# The simulator may stop early on an assertion, so the log decides
./obj_dir/sim_rsa 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// ==== test/rsa_input.hex ====
// Per test, one value per line: M, E, X, R mod M, R^2 mod M, exp_len, expected X^E mod M
00000000000000001fffffffffffffff
000000000000000000000000000000a5
00000000000000001ffffffffffffffe
00000000000000000000000000000040
00000000000000000000000000001000
00000000000000000000000000000008
00000000000000001ffffffffffffffe
0000000000000000000000007fffffff
00000000000000000000000000000001
00000000000000000000000012345678
00000000000000000000000000000010
00000000000000000000000000000100
00000000000000000000000000000001
00000000000000000000000012345678
00000000000000001fffffffffffffff
0000000000000000000000000000000b
00000000000000000000000000001000
00000000000000000000000000000040
00000000000000000000000000001000
00000000000000000000000000000008
00000000000000000000000000000400
